/* logic/core_pkg.sv */
/*
 * shared types and constants for the rv32i integer pipeline
 * covers data word, pc, register index and raw instruction types
 * and the set of alu operations carried from decode to execute
 */
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int SHAMT_W    = 5;
    localparam int PC_INCR    = 4;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [XLEN-1:0]       pc_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0]           instr_t;

    // operations the execute step knows about
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } alu_op_t;

endpackage

/* logic/isa_pkg.sv */
/*
 * rv32i encodings for the supported integer subset
 * opcodes and function fields used by the instruction decoder
 */
package isa_pkg;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // major opcodes
    localparam opcode_t OPCODE_OP     = 7'b0110011;
    localparam opcode_t OPCODE_OP_IMM = 7'b0010011;
    localparam opcode_t OPCODE_LUI    = 7'b0110111;

    // funct3, shared by register and immediate forms
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // funct7 values
    localparam funct7_t FUNCT7_ZERO = 7'b0000000;
    localparam funct7_t FUNCT7_ALT  = 7'b0100000;

endpackage

/* logic/fetch_stage.sv */
/*
 * fetch step of the pipeline
 * keeps the next program counter and latches every accepted
 * instruction word together with its pc for the decode step
 */
`timescale 1ns/1ps

module fetch_stage #(
    parameter core_pkg::pc_t BOOT_PC = 32'h0000_0000
) (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             soft_rstn_i,
    input  logic             instr_valid_i,
    input  core_pkg::instr_t instr_i,
    output logic             f_valid_o,
    output core_pkg::pc_t    f_pc_o,
    output core_pkg::instr_t f_instr_o
);
    import core_pkg::*;

    pc_t next_pc_q;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            next_pc_q <= BOOT_PC;
            f_valid_o <= 1'b0;
        end else if (!soft_rstn_i) begin
            next_pc_q <= BOOT_PC;
            f_valid_o <= 1'b0;
        end else begin
            f_valid_o <= instr_valid_i;
            // one word per accepted instruction
            if (instr_valid_i) begin
                next_pc_q <= next_pc_q + pc_t'(PC_INCR);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            f_pc_o    <= next_pc_q;
            f_instr_o <= instr_i;
        end
    end

endmodule

/* logic/decode_stage.sv */
/*
 * decode step of the pipeline
 * splits the instruction word, reads the register file, builds
 * immediates and flags encodings outside the supported subset;
 * the outcome is registered toward the execute step
 */
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                soft_rstn_i,
    input  logic                f_valid_i,
    input  core_pkg::pc_t       f_pc_i,
    input  core_pkg::instr_t    f_instr_i,
    output core_pkg::reg_addr_t rs1_addr_o,
    output core_pkg::reg_addr_t rs2_addr_o,
    input  core_pkg::word_t     rs1_data_i,
    input  core_pkg::word_t     rs2_data_i,
    output logic                d_valid_o,
    output core_pkg::pc_t       d_pc_o,
    output core_pkg::reg_addr_t d_rd_o,
    output logic                d_we_o,
    output logic                d_xcpt_o,
    output core_pkg::alu_op_t   d_alu_op_o,
    output core_pkg::word_t     d_op_a_o,
    output core_pkg::word_t     d_op_b_o,
    output core_pkg::reg_addr_t d_rs1_o,
    output core_pkg::reg_addr_t d_rs2_o,
    output logic                d_use_rs1_o,
    output logic                d_use_rs2_o
);
    import core_pkg::*;
    import isa_pkg::*;

    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    reg_addr_t rd;
    word_t     imm_i;
    word_t     imm_u;
    alu_op_t   alu_op;
    logic      legal;
    logic      use_rs1;
    logic      use_rs2;
    word_t     op_b;

    assign opcode     = f_instr_i[6:0];
    assign rd         = f_instr_i[11:7];
    assign funct3     = f_instr_i[14:12];
    assign funct7     = f_instr_i[31:25];
    assign rs1_addr_o = f_instr_i[19:15];
    assign rs2_addr_o = f_instr_i[24:20];

    // sign-extended i-type, u-type in the upper bits
    assign imm_i = {{(XLEN-12){f_instr_i[31]}}, f_instr_i[31:20]};
    assign imm_u = {f_instr_i[31:12], 12'b0};

    // alt picks sub over add and sra over srl
    function automatic alu_op_t f3_to_op(funct3_t f3, logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            F3_AND:     return ALU_AND;
            default:    return ALU_ADD;
        endcase
    endfunction

    always_comb begin
        alu_op  = ALU_ADD;
        legal   = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        op_b    = rs2_data_i;
        case (opcode)
            OPCODE_OP: begin
                alu_op  = f3_to_op(funct3, funct7 == FUNCT7_ALT);
                legal   = (funct7 == FUNCT7_ZERO) ||
                          (funct7 == FUNCT7_ALT &&
                           (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            OPCODE_OP_IMM: begin
                // upper immediate bits only matter for shifts
                alu_op  = f3_to_op(funct3, funct3 == F3_SRL_SRA && funct7 == FUNCT7_ALT);
                legal   = 1'b1;
                if (funct3 == F3_SLL) begin
                    legal = (funct7 == FUNCT7_ZERO);
                end
                if (funct3 == F3_SRL_SRA) begin
                    legal = (funct7 == FUNCT7_ZERO) || (funct7 == FUNCT7_ALT);
                end
                use_rs1 = 1'b1;
                op_b    = imm_i;
            end
            OPCODE_LUI: begin
                alu_op = ALU_LUI;
                legal  = 1'b1;
                op_b   = imm_u;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            d_valid_o <= 1'b0;
            d_we_o    <= 1'b0;
            d_xcpt_o  <= 1'b0;
        end else if (!soft_rstn_i) begin
            d_valid_o <= 1'b0;
            d_we_o    <= 1'b0;
            d_xcpt_o  <= 1'b0;
        end else begin
            d_valid_o <= f_valid_i;
            d_xcpt_o  <= f_valid_i && !legal;
            // x0 never becomes a write target
            d_we_o    <= f_valid_i && legal && (rd != '0);
        end
    end

    always_ff @(posedge clk_i) begin
        d_pc_o      <= f_pc_i;
        d_rd_o      <= rd;
        d_alu_op_o  <= alu_op;
        d_op_a_o    <= rs1_data_i;
        d_op_b_o    <= op_b;
        d_rs1_o     <= rs1_addr_o;
        d_rs2_o     <= rs2_addr_o;
        d_use_rs1_o <= use_rs1 && legal;
        d_use_rs2_o <= use_rs2 && legal;
    end

endmodule

/* logic/regfile.sv */
/*
 * integer register file, two read ports and one write port
 * reads are combinational and see a write of the same cycle;
 * register zero is hard-wired to zero
 */
`timescale 1ns/1ps

module regfile (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                we_i,
    input  core_pkg::reg_addr_t waddr_i,
    input  core_pkg::word_t     wdata_i,
    input  core_pkg::reg_addr_t raddr1_i,
    input  core_pkg::reg_addr_t raddr2_i,
    output core_pkg::word_t     rdata1_o,
    output core_pkg::word_t     rdata2_o
);
    import core_pkg::*;

    word_t regs_q [NUM_REGS];

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // write-through so a dependent read two slots behind needs no stall
    assign rdata1_o = (raddr1_i == '0)                 ? '0      :
                      (we_i && waddr_i == raddr1_i)    ? wdata_i :
                                                         regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0)                 ? '0      :
                      (we_i && waddr_i == raddr2_i)    ? wdata_i :
                                                         regs_q[raddr2_i];

endmodule

/* logic/exe_stage.sv */
/*
 * execute step of the pipeline
 * patches register operands from the commit-step bypass, runs the
 * alu and registers the result toward the commit step
 */
`timescale 1ns/1ps

module exe_stage (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                soft_rstn_i,
    input  logic                d_valid_i,
    input  core_pkg::pc_t       d_pc_i,
    input  core_pkg::reg_addr_t d_rd_i,
    input  logic                d_we_i,
    input  logic                d_xcpt_i,
    input  core_pkg::alu_op_t   d_alu_op_i,
    input  core_pkg::word_t     d_op_a_i,
    input  core_pkg::word_t     d_op_b_i,
    input  core_pkg::reg_addr_t d_rs1_i,
    input  core_pkg::reg_addr_t d_rs2_i,
    input  logic                d_use_rs1_i,
    input  logic                d_use_rs2_i,
    input  logic                wb_we_i,
    input  core_pkg::reg_addr_t wb_rd_i,
    input  core_pkg::word_t     wb_data_i,
    output logic                x_valid_o,
    output core_pkg::pc_t       x_pc_o,
    output core_pkg::reg_addr_t x_rd_o,
    output logic                x_we_o,
    output logic                x_xcpt_o,
    output core_pkg::word_t     x_result_o
);
    import core_pkg::*;

    word_t              opnd_a;
    word_t              opnd_b;
    word_t              result;
    logic [SHAMT_W-1:0] shamt;

    // the instruction one slot ahead has not reached the register file yet
    assign opnd_a = (d_use_rs1_i && wb_we_i && wb_rd_i == d_rs1_i) ? wb_data_i : d_op_a_i;
    assign opnd_b = (d_use_rs2_i && wb_we_i && wb_rd_i == d_rs2_i) ? wb_data_i : d_op_b_i;
    assign shamt  = opnd_b[SHAMT_W-1:0];

    always_comb begin
        case (d_alu_op_i)
            ALU_ADD:  result = opnd_a + opnd_b;
            ALU_SUB:  result = opnd_a - opnd_b;
            ALU_AND:  result = opnd_a & opnd_b;
            ALU_OR:   result = opnd_a | opnd_b;
            ALU_XOR:  result = opnd_a ^ opnd_b;
            ALU_SLL:  result = opnd_a << shamt;
            ALU_SRL:  result = opnd_a >> shamt;
            ALU_SRA:  result = word_t'($signed(opnd_a) >>> shamt);
            ALU_SLT:  result = word_t'($signed(opnd_a) < $signed(opnd_b));
            ALU_SLTU: result = word_t'(opnd_a < opnd_b);
            ALU_LUI:  result = opnd_b;
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            x_valid_o <= 1'b0;
            x_we_o    <= 1'b0;
            x_xcpt_o  <= 1'b0;
        end else if (!soft_rstn_i) begin
            x_valid_o <= 1'b0;
            x_we_o    <= 1'b0;
            x_xcpt_o  <= 1'b0;
        end else begin
            x_valid_o <= d_valid_i;
            x_we_o    <= d_valid_i && d_we_i;
            x_xcpt_o  <= d_valid_i && d_xcpt_i;
        end
    end

    always_ff @(posedge clk_i) begin
        x_pc_o     <= d_pc_i;
        x_rd_o     <= d_rd_i;
        x_result_o <= result;
    end

endmodule

/* logic/commit_stage.sv */
/*
 * commit step of the pipeline
 * writes finished results into the register file, feeds them back
 * to the execute step and reports each instruction on the commit port
 */
`timescale 1ns/1ps

module commit_stage (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                soft_rstn_i,
    input  logic                x_valid_i,
    input  core_pkg::pc_t       x_pc_i,
    input  core_pkg::reg_addr_t x_rd_i,
    input  logic                x_we_i,
    input  logic                x_xcpt_i,
    input  core_pkg::word_t     x_result_i,
    output logic                wb_we_o,
    output core_pkg::reg_addr_t wb_rd_o,
    output core_pkg::word_t     wb_data_o,
    output logic                commit_valid_o,
    output core_pkg::pc_t       commit_pc_o,
    output core_pkg::reg_addr_t commit_rd_o,
    output logic                commit_we_o,
    output core_pkg::word_t     commit_data_o,
    output logic                commit_xcpt_o
);
    import core_pkg::*;

    // an instruction caught by a soft reset must leave no trace
    assign wb_we_o   = x_valid_i && x_we_i && !x_xcpt_i && soft_rstn_i;
    assign wb_rd_o   = x_rd_i;
    assign wb_data_o = x_result_i;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            commit_valid_o <= 1'b0;
            commit_we_o    <= 1'b0;
            commit_xcpt_o  <= 1'b0;
            commit_pc_o    <= '0;
            commit_rd_o    <= '0;
            commit_data_o  <= '0;
        end else if (!soft_rstn_i) begin
            commit_valid_o <= 1'b0;
            commit_we_o    <= 1'b0;
            commit_xcpt_o  <= 1'b0;
        end else begin
            commit_valid_o <= x_valid_i;
            commit_we_o    <= wb_we_o;
            commit_xcpt_o  <= x_valid_i && x_xcpt_i;
            commit_pc_o    <= x_pc_i;
            commit_rd_o    <= x_rd_i;
            // faulting instructions report their own pc as data
            commit_data_o  <= x_xcpt_i ? word_t'(x_pc_i) : x_result_i;
        end
    end

endmodule

/* logic/datapath.sv */
/*
 * top level of the four-step rv32i integer pipeline
 * takes a stream of instruction words marked by instr_valid_i and
 * reports every instruction in program order on the commit port;
 * BOOT_PC sets the pc after reset and after a soft reset
 */
`timescale 1ns/1ps

module datapath #(
    parameter core_pkg::pc_t BOOT_PC = 32'h0000_0000
) (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                soft_rstn_i,
    input  logic                instr_valid_i,
    input  core_pkg::instr_t    instr_i,
    output logic                commit_valid_o,
    output core_pkg::pc_t       commit_pc_o,
    output core_pkg::reg_addr_t commit_rd_o,
    output logic                commit_we_o,
    output core_pkg::word_t     commit_data_o,
    output logic                commit_xcpt_o
);
    import core_pkg::*;

    // fetch to decode
    logic      f_valid;
    pc_t       f_pc;
    instr_t    f_instr;

    // register file reads
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    // decode to execute
    logic      d_valid;
    pc_t       d_pc;
    reg_addr_t d_rd;
    logic      d_we;
    logic      d_xcpt;
    alu_op_t   d_alu_op;
    word_t     d_op_a;
    word_t     d_op_b;
    reg_addr_t d_rs1;
    reg_addr_t d_rs2;
    logic      d_use_rs1;
    logic      d_use_rs2;

    // execute to commit
    logic      x_valid;
    pc_t       x_pc;
    reg_addr_t x_rd;
    logic      x_we;
    logic      x_xcpt;
    word_t     x_result;

    // write-back, also the bypass source
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    fetch_stage #(
        .BOOT_PC(BOOT_PC)
    ) fetch_stage_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .soft_rstn_i  (soft_rstn_i),
        .instr_valid_i(instr_valid_i),
        .instr_i      (instr_i),
        .f_valid_o    (f_valid),
        .f_pc_o       (f_pc),
        .f_instr_o    (f_instr)
    );

    decode_stage decode_stage_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .soft_rstn_i(soft_rstn_i),
        .f_valid_i  (f_valid),
        .f_pc_i     (f_pc),
        .f_instr_i  (f_instr),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .d_valid_o  (d_valid),
        .d_pc_o     (d_pc),
        .d_rd_o     (d_rd),
        .d_we_o     (d_we),
        .d_xcpt_o   (d_xcpt),
        .d_alu_op_o (d_alu_op),
        .d_op_a_o   (d_op_a),
        .d_op_b_o   (d_op_b),
        .d_rs1_o    (d_rs1),
        .d_rs2_o    (d_rs2),
        .d_use_rs1_o(d_use_rs1),
        .d_use_rs2_o(d_use_rs2)
    );

    regfile regfile_inst (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .we_i    (wb_we),
        .waddr_i (wb_rd),
        .wdata_i (wb_data),
        .raddr1_i(rs1_addr),
        .raddr2_i(rs2_addr),
        .rdata1_o(rs1_data),
        .rdata2_o(rs2_data)
    );

    exe_stage exe_stage_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .soft_rstn_i(soft_rstn_i),
        .d_valid_i  (d_valid),
        .d_pc_i     (d_pc),
        .d_rd_i     (d_rd),
        .d_we_i     (d_we),
        .d_xcpt_i   (d_xcpt),
        .d_alu_op_i (d_alu_op),
        .d_op_a_i   (d_op_a),
        .d_op_b_i   (d_op_b),
        .d_rs1_i    (d_rs1),
        .d_rs2_i    (d_rs2),
        .d_use_rs1_i(d_use_rs1),
        .d_use_rs2_i(d_use_rs2),
        .wb_we_i    (wb_we),
        .wb_rd_i    (wb_rd),
        .wb_data_i  (wb_data),
        .x_valid_o  (x_valid),
        .x_pc_o     (x_pc),
        .x_rd_o     (x_rd),
        .x_we_o     (x_we),
        .x_xcpt_o   (x_xcpt),
        .x_result_o (x_result)
    );

    commit_stage commit_stage_inst (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .soft_rstn_i   (soft_rstn_i),
        .x_valid_i     (x_valid),
        .x_pc_i        (x_pc),
        .x_rd_i        (x_rd),
        .x_we_i        (x_we),
        .x_xcpt_i      (x_xcpt),
        .x_result_i    (x_result),
        .wb_we_o       (wb_we),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data),
        .commit_valid_o(commit_valid_o),
        .commit_pc_o   (commit_pc_o),
        .commit_rd_o   (commit_rd_o),
        .commit_we_o   (commit_we_o),
        .commit_data_o (commit_data_o),
        .commit_xcpt_o (commit_xcpt_o)
    );

endmodule

/* verification/datapath_assert.sv */
/*
 * concurrent checks on the commit port of the pipeline
 * attached to every datapath instance through the bind below
 */
`timescale 1ns/1ps

module datapath_assert (
    input logic                clk_i,
    input logic                rstn_i,
    input logic                commit_valid_i,
    input core_pkg::pc_t       commit_pc_i,
    input core_pkg::reg_addr_t commit_rd_i,
    input logic                commit_we_i,
    input logic                commit_xcpt_i
);

    // number of assertion failures seen so far
    int fail_cnt = 0;

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(commit_xcpt_i && commit_we_i))
        else begin
            $error("commit reports an exception together with a register write");
            fail_cnt++;
        end

    // x0 is never a write target
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(commit_we_i && commit_rd_i == '0))
        else begin
            $error("commit writes register zero");
            fail_cnt++;
        end

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        commit_valid_i |-> commit_pc_i[1:0] == 2'b00)
        else begin
            $error("committed pc is not word aligned");
            fail_cnt++;
        end

    assert property (@(posedge clk_i)
        $rose(rstn_i) |-> !commit_valid_i && !commit_we_i && !commit_xcpt_i)
        else begin
            $error("commit port active right after reset release");
            fail_cnt++;
        end

endmodule

bind datapath datapath_assert datapath_assert_inst (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .commit_valid_i(commit_valid_o),
    .commit_pc_i   (commit_pc_o),
    .commit_rd_i   (commit_rd_o),
    .commit_we_i   (commit_we_o),
    .commit_xcpt_i (commit_xcpt_o)
);

/* verification/tb_datapath.sv */
/*
 * testbench for the rv32i integer pipeline
 * drives a random instruction stream on the falling clock edge, keeps
 * an isa-level model of the register file and compares every commit
 * against the expected result; soft resets are injected mid-stream
 */
`timescale 1ns/1ps

module tb_datapath;
    import core_pkg::*;

    localparam pc_t         BOOT_PC    = 32'h0000_1000;
    localparam int          NUM_CYCLES = 1200;
    localparam logic [15:0] SEED       = 16'd52242;
    localparam logic [6:0]  OPC_OP     = 7'b0110011;
    localparam logic [6:0]  OPC_IMM    = 7'b0010011;
    localparam logic [6:0]  OPC_LUI    = 7'b0110111;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        we;
        logic [31:0] data;
        logic        xcpt;
    } exp_commit_t;

    logic      clk_i = 1'b0;
    logic      rstn_i;
    logic      soft_rstn_i;
    logic      instr_valid_i;
    instr_t    instr_i;
    logic      commit_valid_o;
    pc_t       commit_pc_o;
    reg_addr_t commit_rd_o;
    logic      commit_we_o;
    word_t     commit_data_o;
    logic      commit_xcpt_o;

    logic [15:0]  lfsr;
    logic [31:0]  spec_regs [32];
    logic [31:0]  arch_regs [32];
    logic [31:0]  model_pc;
    exp_commit_t  exp_q [$];
    int           errors;
    int           checked;

    datapath #(
        .BOOT_PC(BOOT_PC)
    ) UUT (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .soft_rstn_i   (soft_rstn_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .commit_valid_o(commit_valid_o),
        .commit_pc_o   (commit_pc_o),
        .commit_rd_o   (commit_rd_o),
        .commit_we_o   (commit_we_o),
        .commit_data_o (commit_data_o),
        .commit_xcpt_o (commit_xcpt_o)
    );

    always #4 clk_i = ~clk_i;

    // 16-bit galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // reference alu from the isa description
    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt,
                                            logic [31:0] a, logic [31:0] b);
        logic signed [31:0] sra;
        sra = $signed(a) >>> b[4:0];
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return sra;
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] gen_instr();
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [19:0] upper;
        logic [24:0] filler;
        kind = take_bits(4);
        // only x0..x7 so that hazards come often
        rd   = take_bits(3);
        rs1  = take_bits(3);
        rs2  = take_bits(3);
        f3   = take_bits(3);
        if (kind == 4'd0) begin
            filler = take_bits(25);
            case (take_bits(2))
                2'd0:    return {filler, 7'b0000011};
                2'd1:    return {filler, 7'b0100011};
                2'd2:    return {filler, 7'b1100011};
                default: return {filler, 7'b1110011};
            endcase
        end
        if (kind == 4'd1) begin
            upper = take_bits(20);
            return {upper, rd, OPC_LUI};
        end
        if (kind < 4'd9) begin
            f7 = 7'h00;
            if ((f3 == 3'd0 || f3 == 3'd5) && take_bits(1) == 1) begin
                f7 = 7'h20;
            end
            return {f7, rs2, rs1, f3, rd, OPC_OP};
        end
        imm = take_bits(12);
        if (f3 == 3'd1) begin
            imm[11:5] = 7'h00;
        end
        if (f3 == 3'd5) begin
            imm[11:5] = (take_bits(1) == 1) ? 7'h20 : 7'h00;
        end
        return {imm, rs1, f3, rd, OPC_IMM};
    endfunction

    // expected commit of one accepted instruction, in program order
    task automatic model_instr(input logic [31:0] ins);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] res;
        logic        ok;
        exp_commit_t e;
        opc = ins[6:0];
        f3  = ins[14:12];
        f7  = ins[31:25];
        a   = spec_regs[ins[19:15]];
        res = '0;
        ok  = 1'b1;
        if (opc == OPC_OP) begin
            ok  = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            res = alu_ref(f3, f7[5], a, spec_regs[ins[24:20]]);
        end else if (opc == OPC_IMM) begin
            if (f3 == 3'd1) begin
                ok = (f7 == 7'h00);
            end
            if (f3 == 3'd5) begin
                ok = (f7 == 7'h00) || (f7 == 7'h20);
            end
            res = alu_ref(f3, f3 == 3'd5 && f7[5], a, {{20{ins[31]}}, ins[31:20]});
        end else if (opc == OPC_LUI) begin
            res = {ins[31:12], 12'h000};
        end else begin
            ok = 1'b0;
        end
        e.pc   = model_pc;
        e.rd   = ins[11:7];
        e.we   = ok && (ins[11:7] != 5'd0);
        e.xcpt = !ok;
        e.data = ok ? res : model_pc;
        if (e.we) begin
            spec_regs[e.rd] = res;
        end
        exp_q.push_back(e);
        model_pc = model_pc + 32'd4;
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_commit();
        exp_commit_t e;
        if (commit_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("commit at pc %h appeared with no instruction outstanding",
                         commit_pc_o);
                errors++;
            end else begin
                e = exp_q.pop_front();
                checked++;
                check_field("commit_pc_o", commit_pc_o, e.pc);
                check_field("commit_rd_o", 32'(commit_rd_o), 32'(e.rd));
                check_field("commit_we_o", 32'(commit_we_o), 32'(e.we));
                check_field("commit_xcpt_o", 32'(commit_xcpt_o), 32'(e.xcpt));
                check_field("commit_data_o", commit_data_o, e.data);
                if (e.we) begin
                    arch_regs[e.rd] = e.data;
                end
            end
        end else if (commit_valid_o !== 1'b0) begin
            $display("commit_valid_o is unknown during the run");
            errors++;
        end
    endtask

    // everything still queued sits in fetch, decode or execute
    task automatic flush_inflight();
        exp_q.delete();
        spec_regs = arch_regs;
        model_pc  = BOOT_PC;
    endtask

    initial begin
        int soft_hold;
        int wait_cnt;
        int assert_fails;
        rstn_i        = 1'b0;
        soft_rstn_i   = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        lfsr          = SEED;
        errors        = 0;
        checked       = 0;
        soft_hold     = 0;
        model_pc      = BOOT_PC;
        for (int r = 0; r < 32; r++) begin
            spec_regs[r] = '0;
            arch_regs[r] = '0;
        end
        repeat (3) @(negedge clk_i);
        rstn_i   = 1'b1;
        wait_cnt = 0;
        while (commit_valid_o !== 1'b0 && wait_cnt < 10) begin
            @(negedge clk_i);
            wait_cnt++;
        end
        if (commit_valid_o !== 1'b0) begin
            $display("timeout: commit port did not go idle after reset");
            errors++;
        end
        // idle stretch, nothing may commit here
        for (int i = 0; i < 4; i++) begin
            @(negedge clk_i);
            check_commit();
        end
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(negedge clk_i);
            check_commit();
            if (cyc == 400 || cyc == 850) begin
                soft_hold = 2;
            end
            if (soft_hold > 0) begin
                soft_hold--;
                soft_rstn_i   = 1'b0;
                instr_valid_i = 1'b0;
                flush_inflight();
            end else begin
                soft_rstn_i = 1'b1;
                if (take_bits(3) == 0) begin
                    instr_valid_i = 1'b0;
                end else begin
                    instr_i       = gen_instr();
                    instr_valid_i = 1'b1;
                    model_instr(instr_i);
                end
            end
        end
        @(negedge clk_i);
        check_commit();
        instr_valid_i = 1'b0;
        wait_cnt      = 0;
        while (exp_q.size() != 0 && wait_cnt < 20) begin
            @(negedge clk_i);
            check_commit();
            wait_cnt++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d instructions never committed", exp_q.size());
            errors++;
        end
        assert_fails = UUT.datapath_assert_inst.fail_cnt;
        $display("%0d commits checked, %0d errors, %0d assertion failures",
                 checked, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* list.f */
logic/core_pkg.sv
logic/isa_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/regfile.sv
logic/exe_stage.sv
logic/commit_stage.sv
logic/datapath.sv
verification/datapath_assert.sv
verification/tb_datapath.sv

/* Bender.yml */
package:
  name: datapath

sources:
  # packages first, then the pipeline steps and the top level
  - logic/core_pkg.sv
  - logic/isa_pkg.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/regfile.sv
  - logic/exe_stage.sv
  - logic/commit_stage.sv
  - logic/datapath.sv

  - target: test
    files:
      - verification/datapath_assert.sv
      - verification/tb_datapath.sv
